// File: hw/cpu_mem_pkg.sv
package cpu_mem_pkg;

  // memory geometry
  localparam int word_w     = 16;
  localparam int addr_w     = 10;
  localparam int ram_depth  = 1024;

  // paging
  localparam int page_size  = 72;       // words per page
  localparam int page_count = 14;       // whole pages that fit in ram
  localparam int page_idx_w = 4;

  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [word_w-1:0]     word_t;
  typedef logic [page_idx_w-1:0] page_idx_t;

  // request from the core to the mmu, logical address
  typedef struct packed {
    addr_t addr;
    logic  wr;                          // 1 = store, 0 = read
    word_t data;
  } mem_req_t;

  // ram write port, physical address
  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t data;
  } mem_wr_t;

endpackage

// File: hw/cpu_isa_pkg.sv
package cpu_isa_pkg;

  localparam int reg_count = 32;
  localparam int reg_idx_w = 5;

  typedef logic [reg_idx_w-1:0] reg_idx_t;

  // opcode lives in the high byte of the first instruction word
  typedef enum logic [7:0] {
    op_jmp            = 8'd1,
    op_ram2reg        = 8'd2,
    op_reg2ram        = 8'd3,
    op_num2reg        = 8'd4,
    op_reg_plus       = 8'd5,
    op_reg_minus      = 8'd6,
    op_till_value     = 8'd9,
    op_till_non_value = 8'd10,
    op_loop           = 8'd11,
    op_exit           = 8'd17
  } opcode_e;

  typedef enum logic [1:0] {
    loop_till_value,
    loop_till_non_value,
    loop_for
  } loop_kind_e;

  typedef enum logic [3:0] {
    st_idle,
    st_fetch_op,
    st_fetch_operand,
    st_decode,
    st_mem_wait,                        // store in flight
    st_load_data,                       // load in flight
    st_halted
  } stage_e;

  // both instruction words side by side
  typedef struct packed {
    opcode_e              op;
    logic [7:0]           reg_num;
    cpu_mem_pkg::word_t   operand;      // loops: compare value high, body length low
  } instr_t;

  typedef struct packed {
    logic               valid;
    reg_idx_t           idx;
    cpu_mem_pkg::word_t data;
  } reg_wr_t;

  localparam cpu_mem_pkg::addr_t reset_pc = '0;

endpackage

// File: hw/program_ram.sv
`timescale 1ns/100ps

module program_ram (
  input  logic                 clka,
  input  cpu_mem_pkg::mem_wr_t load,
  input  cpu_mem_pkg::mem_wr_t core_wr,
  input  cpu_mem_pkg::addr_t   rd_addr,
  output cpu_mem_pkg::word_t   rd_data
);
  import cpu_mem_pkg::*;

  word_t   mem [ram_depth];
  mem_wr_t wr;

  // testbench load wins over the core
  assign wr = load.valid ? load : core_wr;

  always_ff @(posedge clka) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.data;
    end
    rd_data <= mem[rd_addr];            // one cycle read latency
  end

endmodule

// File: hw/page_mmu.sv
`timescale 1ns/100ps

module page_mmu (
  input  logic                  clka,
  input  logic                  rst,
  input  logic                  mmu_req,
  input  cpu_mem_pkg::mem_req_t req,
  output logic                  done,
  output logic                  fault,
  output cpu_mem_pkg::addr_t    phys_addr,
  output cpu_mem_pkg::mem_wr_t  core_wr
);
  import cpu_mem_pkg::*;

  typedef enum logic [1:0] {
    mmu_wait,
    mmu_walk,
    mmu_allocate,
    mmu_found
  } mmu_state_e;

  mmu_state_e state;

  page_idx_t chain [page_count];        // next physical page, self at chain end
  page_idx_t tag   [page_count];        // logical page held, 0 = free

  page_idx_t last_lpage;                // cached last translation
  page_idx_t last_ppage;
  page_idx_t walk_page;                 // current page, then the result
  page_idx_t tail_page;
  page_idx_t next_free;                 // allocation scan pointer

  mem_req_t  cur_req;
  page_idx_t req_lpage;
  addr_t     req_offset;
  page_idx_t cur_lpage;
  addr_t     cur_offset;
  logic      walk_match;

  function automatic addr_t to_phys(page_idx_t page, addr_t offset);
    return addr_t'(page * page_size) + offset;
  endfunction

  assign req_lpage  = page_idx_t'(req.addr / page_size);
  assign req_offset = addr_t'(req.addr % page_size);
  assign cur_lpage  = page_idx_t'(cur_req.addr / page_size);
  assign cur_offset = addr_t'(cur_req.addr % page_size);

  // page 0 always holds logical page 0, its tag only marks it used
  assign walk_match = (walk_page == '0) ? (cur_lpage == '0) : (tag[walk_page] == cur_lpage);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state         <= mmu_wait;
      done          <= 1'b0;
      fault         <= 1'b0;
      phys_addr     <= '0;
      core_wr       <= '0;
      last_lpage    <= '0;
      last_ppage    <= '0;
      walk_page     <= '0;
      tail_page     <= '0;
      next_free     <= page_idx_t'(1);
      for (int i = 0; i < page_count; i++) begin
        chain[i] <= '0;
        tag[i]   <= '0;
      end
      tag[0] <= page_idx_t'(1);         // page 0 taken, points to itself
    end else begin
      done          <= 1'b0;
      fault         <= 1'b0;
      core_wr.valid <= 1'b0;
      case (state)
        mmu_wait: begin
          if (mmu_req) begin
            cur_req <= req;
            if (req_lpage == last_lpage) begin
              done      <= 1'b1;        // hit, answer next cycle
              phys_addr <= to_phys(last_ppage, req_offset);
              core_wr   <= '{valid: req.wr, addr: to_phys(last_ppage, req_offset),
                             data: req.data};
            end else begin
              walk_page <= '0;
              state     <= mmu_walk;
            end
          end
        end
        mmu_walk: begin
          if (walk_match) begin
            state <= mmu_found;
          end else if (chain[walk_page] == walk_page) begin
            tail_page <= walk_page;     // end of chain
            state     <= mmu_allocate;
          end else begin
            walk_page <= chain[walk_page];
          end
        end
        mmu_allocate: begin
          if (next_free >= page_idx_t'(page_count)) begin
            done  <= 1'b1;              // out of pages
            fault <= 1'b1;
            state <= mmu_wait;
          end else if (tag[next_free] == '0) begin
            chain[tail_page] <= next_free;
            chain[next_free] <= next_free;
            tag[next_free]   <= cur_lpage;
            walk_page        <= next_free;
            next_free        <= next_free + 1'b1;
            state            <= mmu_found;
          end else begin
            next_free <= next_free + 1'b1;
          end
        end
        mmu_found: begin
          done       <= 1'b1;
          phys_addr  <= to_phys(walk_page, cur_offset);
          core_wr    <= '{valid: cur_req.wr, addr: to_phys(walk_page, cur_offset),
                          data: cur_req.data};
          last_lpage <= cur_lpage;
          last_ppage <= walk_page;
          state      <= mmu_wait;
        end
        default: state <= mmu_wait;
      endcase
    end
  end

endmodule

// File: hw/loop_unit.sv
`timescale 1ns/100ps

module loop_unit (
  input  logic                  clka,
  input  logic                  rst,
  input  logic                  set,
  input  cpu_isa_pkg::instr_t   instr,
  input  logic                  retire,
  input  cpu_mem_pkg::word_t    loop_reg_val,
  output cpu_isa_pkg::reg_idx_t loop_reg,
  output logic                  rewind,
  output cpu_mem_pkg::addr_t    pc_back
);
  import cpu_isa_pkg::*;
  import cpu_mem_pkg::*;

  logic       active;
  loop_kind_e kind;
  logic [7:0] body_len;                 // instructions in the body
  logic [7:0] done_cnt;                 // body instructions retired this pass
  logic [7:0] cmp_val;
  logic       body_end;
  logic       again;

  // set wins, the loop opcode itself is not part of the body
  assign body_end = active && retire && !set && (done_cnt + 8'd1 == body_len);

  always_comb begin
    case (kind)
      loop_till_value:     again = loop_reg_val != word_t'(cmp_val);
      loop_till_non_value: again = loop_reg_val == word_t'(cmp_val);
      loop_for:            again = cmp_val != '0;
      default:             again = 1'b0;
    endcase
  end

  assign rewind  = body_end && again;
  assign pc_back = addr_t'({body_len, 1'b0}); // two words per instruction

  always_ff @(posedge clka) begin
    if (!rst) begin
      active   <= 1'b0;
      kind     <= loop_till_value;
      body_len <= '0;
      done_cnt <= '0;
      cmp_val  <= '0;
      loop_reg <= '0;
    end else if (set) begin
      active   <= instr.operand[7:0] != '0; // empty body does nothing
      body_len <= instr.operand[7:0];
      cmp_val  <= instr.operand[15:8];
      loop_reg <= instr.reg_num[reg_idx_w-1:0];
      done_cnt <= '0;
      case (instr.op)
        op_till_value:     kind <= loop_till_value;
        op_till_non_value: kind <= loop_till_non_value;
        default:           kind <= loop_for;
      endcase
    end else if (active && retire) begin
      if (body_end) begin
        done_cnt <= '0;
        if (!again) begin
          active <= 1'b0;               // leave the loop
        end else if (kind == loop_for) begin
          cmp_val <= cmp_val - 8'd1;
        end
      end else begin
        done_cnt <= done_cnt + 8'd1;
      end
    end
  end

endmodule

// File: hw/core_sequencer.sv
`timescale 1ns/100ps

module core_sequencer (
  input  logic                  clka,
  input  logic                  rst,
  input  logic                  start,
  output logic                  mmu_req,
  output cpu_mem_pkg::mem_req_t req,
  input  logic                  done,
  input  logic                  fault,
  input  cpu_mem_pkg::word_t    rd_data,
  output logic                  loop_set,
  output cpu_isa_pkg::instr_t   loop_instr,
  output logic                  retire,
  input  cpu_isa_pkg::reg_idx_t loop_reg,
  output cpu_mem_pkg::word_t    loop_reg_val,
  input  logic                  rewind,
  input  cpu_mem_pkg::addr_t    pc_back,
  output cpu_isa_pkg::reg_wr_t  reg_trace,
  output logic                  halted
);
  import cpu_isa_pkg::*;
  import cpu_mem_pkg::*;

  stage_e   stage;
  addr_t    pc;
  instr_t   cur;                        // instruction being executed
  word_t    regs [reg_count];
  logic     rd_valid;                   // rd_data holds a read result
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_data;
  logic     jump;
  addr_t    base_pc;
  addr_t    next_pc;

  assign wr_idx     = cur.reg_num[reg_idx_w-1:0];
  assign loop_instr = cur;
  assign halted     = stage == st_halted;

  // forward a same-cycle register write to the loop check
  assign loop_reg_val = (wr_en && wr_idx == loop_reg) ? wr_data : regs[loop_reg];

  assign base_pc = jump ? cur.operand[addr_w-1:0] : pc;
  assign next_pc = rewind ? base_pc - pc_back : base_pc;

  always_comb begin
    retire   = 1'b0;
    loop_set = 1'b0;
    wr_en    = 1'b0;
    wr_data  = rd_data;
    jump     = 1'b0;
    case (stage)
      st_decode: begin
        case (cur.op)
          op_jmp: begin
            jump   = 1'b1;
            retire = 1'b1;
          end
          op_num2reg: begin
            wr_en   = 1'b1;
            wr_data = cur.operand;
            retire  = 1'b1;
          end
          op_reg_plus: begin
            wr_en   = 1'b1;
            wr_data = regs[wr_idx] + cur.operand; // wraps mod 2^16
            retire  = 1'b1;
          end
          op_reg_minus: begin
            wr_en   = 1'b1;
            wr_data = regs[wr_idx] - cur.operand;
            retire  = 1'b1;
          end
          op_till_value, op_till_non_value, op_loop: begin
            loop_set = 1'b1;
            retire   = 1'b1;
          end
          op_ram2reg, op_reg2ram, op_exit: retire = 1'b0;
          default: retire = 1'b1;           // unknown opcode, skip
        endcase
      end
      st_mem_wait: retire = done && !fault;
      st_load_data: begin
        wr_en  = rd_valid;
        retire = rd_valid;
      end
      default: retire = 1'b0;
    endcase
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      stage     <= st_idle;
      pc        <= reset_pc;
      mmu_req   <= 1'b0;
      rd_valid  <= 1'b0;
      reg_trace <= '0;
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      mmu_req   <= 1'b0;
      rd_valid  <= done && !fault && !req.wr;
      reg_trace <= '{valid: wr_en, idx: wr_idx, data: wr_data};
      if (wr_en) begin
        regs[wr_idx] <= wr_data;
      end
      if (retire) begin
        pc      <= next_pc;             // fetch the next instruction
        mmu_req <= 1'b1;
        req     <= '{addr: next_pc, wr: 1'b0, data: '0};
        stage   <= st_fetch_op;
      end else if (done && fault) begin
        stage <= st_halted;
      end else begin
        case (stage)
          st_idle: begin
            if (start) begin
              mmu_req <= 1'b1;
              req     <= '{addr: pc, wr: 1'b0, data: '0};
              stage   <= st_fetch_op;
            end
          end
          st_fetch_op: begin
            if (rd_valid) begin
              cur.op      <= opcode_e'(rd_data[15:8]);
              cur.reg_num <= rd_data[7:0];
              pc          <= pc + 1'b1;
              mmu_req     <= 1'b1;
              req         <= '{addr: pc + 1'b1, wr: 1'b0, data: '0};
              stage       <= st_fetch_operand;
            end
          end
          st_fetch_operand: begin
            if (rd_valid) begin
              cur.operand <= rd_data;
              pc          <= pc + 1'b1;
              stage       <= st_decode;
            end
          end
          st_decode: begin
            case (cur.op)
              op_ram2reg: begin
                mmu_req <= 1'b1;
                req     <= '{addr: cur.operand[addr_w-1:0], wr: 1'b0, data: '0};
                stage   <= st_load_data;
              end
              op_reg2ram: begin
                mmu_req <= 1'b1;
                req     <= '{addr: cur.operand[addr_w-1:0], wr: 1'b1, data: regs[wr_idx]};
                stage   <= st_mem_wait;
              end
              default: stage <= st_halted;  // exit
            endcase
          end
          default: stage <= stage;      // waiting on the mmu, or halted
        endcase
      end
    end
  end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
  input  logic                 clka,
  input  logic                 rst,
  input  cpu_mem_pkg::mem_wr_t load,
  input  logic                 start,
  output cpu_isa_pkg::reg_wr_t reg_trace,
  output cpu_mem_pkg::mem_wr_t mem_trace,
  output logic                 halted
);
  import cpu_mem_pkg::*;
  import cpu_isa_pkg::*;

  logic     mmu_req;
  mem_req_t req;
  logic     done;
  logic     fault;
  addr_t    phys_addr;
  word_t    rd_data;
  logic     loop_set;
  logic     retire;
  logic     rewind;
  instr_t   loop_instr;
  reg_idx_t loop_reg;
  word_t    loop_reg_val;
  addr_t    pc_back;

  program_ram u_ram (
    .clka    (clka),
    .load    (load),
    .core_wr (mem_trace),               // core stores go straight to ram
    .rd_addr (phys_addr),
    .rd_data (rd_data)
  );

  page_mmu u_mmu (
    .clka      (clka),
    .rst       (rst),
    .mmu_req   (mmu_req),
    .req       (req),
    .done      (done),
    .fault     (fault),
    .phys_addr (phys_addr),
    .core_wr   (mem_trace)
  );

  loop_unit u_loop (
    .clka         (clka),
    .rst          (rst),
    .set          (loop_set),
    .instr        (loop_instr),
    .retire       (retire),
    .loop_reg_val (loop_reg_val),
    .loop_reg     (loop_reg),
    .rewind       (rewind),
    .pc_back      (pc_back)
  );

  core_sequencer u_core (
    .clka         (clka),
    .rst          (rst),
    .start        (start),
    .mmu_req      (mmu_req),
    .req          (req),
    .done         (done),
    .fault        (fault),
    .rd_data      (rd_data),
    .loop_set     (loop_set),
    .loop_instr   (loop_instr),
    .retire       (retire),
    .loop_reg     (loop_reg),
    .loop_reg_val (loop_reg_val),
    .rewind       (rewind),
    .pc_back      (pc_back),
    .reg_trace    (reg_trace),
    .halted       (halted)
  );

endmodule

// File: test/cpu_assert.sv
`timescale 1ns/100ps

module cpu_assert (
  input logic                 clka,
  input logic                 rst,
  input logic                 mmu_req,
  input logic                 done,
  input cpu_mem_pkg::mem_wr_t core_wr,
  input logic                 halted
);
  import cpu_mem_pkg::*;

  int   req_fails  = 0;
  int   addr_fails = 0;
  int   halt_fails = 0;
  int   fail_cnt;
  logic pending;                              // request out, done not seen yet

  assign fail_cnt = req_fails + addr_fails + halt_fails;

  always_ff @(posedge clka) begin
    if (!rst) begin
      pending <= 1'b0;
    end else if (mmu_req) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  done_after_req: assert property (@(posedge clka) disable iff (!rst) done |-> pending)
    else begin
      $error("mmu done without an outstanding request");
      req_fails++;
    end

  // words above the last whole page belong to no page
  wr_in_ram: assert property (@(posedge clka) disable iff (!rst)
      core_wr.valid |-> !$isunknown(core_wr.addr)
                        && int'(core_wr.addr) < page_count * page_size)
    else begin
      $error("core write outside the paged ram");
      addr_fails++;
    end

  halt_sticky: assert property (@(posedge clka) disable iff (!rst) halted |=> halted)
    else begin
      $error("halted fell without reset");
      halt_fails++;
    end

endmodule

bind page_mmu cpu_assert mmu_checks (
  .clka    (clka),
  .rst     (rst),
  .mmu_req (mmu_req),
  .done    (done),
  .core_wr (core_wr),
  .halted  (1'b0)
);

bind core_sequencer cpu_assert core_checks (
  .clka    (clka),
  .rst     (rst),
  .mmu_req (mmu_req),
  .done    (done),
  .core_wr ('0),
  .halted  (halted)
);

// File: test/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;
  import cpu_mem_pkg::*;
  import cpu_isa_pkg::*;

  localparam int    clk_period     = 8;       // ns
  localparam int    reset_cycles   = 10;
  localparam int    timeout_factor = 300;     // cycles allowed per expected record
  localparam int    quiet_cycles   = 20;      // watch time after halt
  localparam string data_file      = "test/cpu_testdata.txt";

  typedef struct packed {
    logic  is_mem;                            // 1 = ram write, 0 = register write
    addr_t addr;                              // register index for register writes
    word_t data;
  } trace_rec_t;

  logic    clka;
  logic    rst;
  logic    start;
  mem_wr_t load;
  reg_wr_t reg_trace;
  mem_wr_t mem_trace;
  logic    halted;

  mem_wr_t    prog_q [$];
  trace_rec_t exp_q [$];
  int         cycle_cnt    = 0;
  int         cycle_limit  = 100;
  int         tests_run    = 0;
  int         tests_failed = 0;
  int         extra_events = 0;
  int         assert_fails = 0;
  int         bad_lines    = 0;

  cpu_top UUT (
    .clka      (clka),
    .rst       (rst),
    .load      (load),
    .start     (start),
    .reg_trace (reg_trace),
    .mem_trace (mem_trace),
    .halted    (halted)
  );

  initial begin
    clka = 1'b0;
    forever #(clk_period / 2) clka = ~clka;
  end

  function automatic string kind_name(input logic is_mem);
    return is_mem ? "M" : "R";
  endfunction

  // P = program word, R = expected register write, M = expected ram write
  task automatic read_records();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen(data_file, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%c %h %h", kind, a, b);
        if (n != 3) begin
          bad_lines++;
          $display("ERROR: unreadable line in data file: %s", line);
          continue;
        end
        case (kind)
          "P": prog_q.push_back(mem_wr_t'{valid: 1'b1, addr: addr_t'(a), data: word_t'(b)});
          "R": exp_q.push_back(trace_rec_t'{is_mem: 1'b0, addr: addr_t'(a), data: word_t'(b)});
          "M": exp_q.push_back(trace_rec_t'{is_mem: 1'b1, addr: addr_t'(a), data: word_t'(b)});
          default: begin
            bad_lines++;
            $display("ERROR: unknown record kind in line: %s", line);
          end
        endcase
      end
      $fclose(fd);
    end
  endtask

  task automatic compare_trace(input logic is_mem, input addr_t addr, input word_t data);
    trace_rec_t got;
    trace_rec_t exp;
    logic       ok;
    got = '{is_mem: is_mem, addr: addr, data: data};
    if (halted === 1'b1 || exp_q.size() == 0) begin
      extra_events++;                         // judged by the quiet test
      $display("ERROR: unexpected trace event %s %h = %h at %0t",
               kind_name(is_mem), addr, data, $time);
    end else begin
      exp = exp_q.pop_front();
      ok  = (got === exp);
      tests_run++;
      assert (ok) else begin
        tests_failed++;
        $display("MISMATCH at %0t: record %0d expected %s %h = %h, got %s %h = %h",
                 $time, tests_run, kind_name(exp.is_mem), exp.addr, exp.data,
                 kind_name(is_mem), addr, data);
      end
      $display("test %0d: %s %h = %h %s", tests_run, kind_name(exp.is_mem),
               exp.addr, exp.data, ok ? "passed" : "failed");
    end
  endtask

  // trace outputs change on the rising edge, look at them mid cycle
  always @(negedge clka) begin
    if (rst === 1'b1) begin
      if (reg_trace.valid === 1'b1) begin
        compare_trace(1'b0, addr_t'(reg_trace.idx), reg_trace.data);
      end
      if (mem_trace.valid === 1'b1) begin
        compare_trace(1'b1, mem_trace.addr, mem_trace.data);
      end
    end
  end

  task automatic run_program();
    int left;
    repeat (reset_cycles) @(posedge clka);
    #1 rst = 1'b1;
    foreach (prog_q[i]) begin
      load = prog_q[i];
      @(posedge clka);
      #1;
    end
    load  = '0;
    start = 1'b1;
    @(posedge clka);
    #1 start = 1'b0;
    while (halted !== 1'b1) begin
      @(posedge clka);
      #2;
    end
    left = exp_q.size();
    tests_run++;
    assert (left == 0) else begin
      tests_failed++;
      $display("ERROR: core halted with %0d expected records not yet seen", left);
    end
    $display("test %0d: all records seen before halt %s", tests_run,
             left == 0 ? "passed" : "failed");
    repeat (quiet_cycles) @(posedge clka);
    tests_run++;
    assert (extra_events == 0) else begin
      tests_failed++;
      $display("ERROR: %0d trace events that no record expected", extra_events);
    end
    $display("test %0d: no trace events beyond the records %s", tests_run,
             extra_events == 0 ? "passed" : "failed");
  endtask

  // timeout, counted from reset release
  initial begin
    wait (rst === 1'b1);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clka);
      cycle_cnt++;
    end
    $display("ERROR: run timed out after %0d cycles", cycle_cnt);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst   = 1'b0;
    start = 1'b0;
    load  = '0;
    read_records();
    cycle_limit = timeout_factor * exp_q.size() + 100;
    tests_run++;
    assert (prog_q.size() > 0 && exp_q.size() > 0 && bad_lines == 0) else begin
      tests_failed++;
      $display("ERROR: no program or expected records, or %0d unreadable lines, in %s",
               bad_lines, data_file);
    end
    if (tests_failed == 0) begin
      run_program();
    end
    assert_fails = UUT.u_mmu.mmu_checks.fail_cnt + UUT.u_core.core_checks.fail_cnt;
    tests_run++;
    assert (assert_fails == 0) else begin
      tests_failed++;
      $display("ERROR: %0d concurrent assertion failures", assert_fails);
    end
    $display("test %0d: protocol assertions %s", tests_run,
             assert_fails == 0 ? "passed" : "failed");
    $display("%0d tests, %0d passed, %0d failed", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: test/cpu_testdata.txt
# P word-address word | R register value | M physical-address value, all hex
# R and M lines are the expected write trace in the order it must appear
P 000 0401
P 001 1234
P 002 0501
P 003 0010
P 004 0601
P 005 0044
P 006 0402
P 007 fff0
P 008 0502
P 009 0025
P 00a 0603
P 00b 0001
P 00c 0301
P 00d 003c
P 00e 0204
P 00f 003c
P 010 0405
P 011 a5a5
P 012 0305
P 013 00dd
P 014 0302
P 015 0052
P 016 0301
P 017 00ec
P 018 0406
P 019 0000
P 01a 0b00
P 01b 0301
P 01c 0506
P 01d 0005
P 01e 0407
P 01f 0000
P 020 0907
P 021 0402
P 022 0507
P 023 0001
P 024 0508
P 025 0010
P 026 0100
P 027 002a
P 028 0409
P 029 dead
P 02a 040a
P 02b 00be
P 02c 1100
P 02d 0000
P 02e 040b
P 02f 0bad
# arithmetic with wrap
R 01 1234
R 01 1244
R 01 1200
R 02 fff0
R 02 0015
R 03 ffff
# store and load in page 0
M 03c 1200
R 04 1200
# logical pages 3, 1, 3 land in physical pages 1, 2, 1
R 05 a5a5
M 04d a5a5
M 09a 0015
M 05c 1200
# counted loop, four passes
R 06 0000
R 06 0005
R 06 000a
R 06 000f
R 06 0014
# till-value loop on r7 up to 4
R 07 0000
R 07 0001
R 08 0010
R 07 0002
R 08 0020
R 07 0003
R 08 0030
R 07 0004
R 08 0040
# jump skips r9, exit stops before r11
R 0a 00be

// File: build.f
hw/cpu_mem_pkg.sv
hw/cpu_isa_pkg.sv
hw/program_ram.sv
hw/page_mmu.sv
hw/loop_unit.sv
hw/core_sequencer.sv
hw/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - hw/cpu_mem_pkg.sv
  - hw/cpu_isa_pkg.sv
  - hw/program_ram.sv
  - hw/page_mmu.sv
  - hw/loop_unit.sv
  - hw/core_sequencer.sv
  - hw/cpu_top.sv
  - target: test
    files:
      - test/cpu_assert.sv
      - test/cpu_tb.sv
